// File: src/hyperbus_params.svh
// HyperBus front end: bus widths and number of transaction sources

`ifndef HYPERBUS_PARAMS_SVH
`define HYPERBUS_PARAMS_SVH

// Sources sharing the PHY channel (AXI slave, uDMA)
`define HB_NUM_SRC 2

// One-hot chip selects
`define HB_NUM_CHIPS 2

// Descriptor fields
`define HB_ADDR_W 32
`define HB_LEN_W 8

// Single PHY, two bytes per beat
`define HB_DATA_W 16
`define HB_STRB_W 2

`endif

// File: src/hyperbus_pkg.sv
// HyperBus bus transfer types: descriptor, write beat and read beat
`default_nettype none

`include "hyperbus_params.svh"

package hyperbus_pkg;

    typedef logic [`HB_ADDR_W-1:0] hb_addr_t;
    // Beats in burst minus one
    typedef logic [`HB_LEN_W-1:0] hb_len_t;
    typedef logic [`HB_DATA_W-1:0] hb_data_t;
    typedef logic [`HB_STRB_W-1:0] hb_strb_t;
    typedef logic [`HB_NUM_CHIPS-1:0] hb_cs_t;

    typedef struct packed {
        hb_addr_t addr;
        hb_len_t  len;
        logic     write;
        hb_cs_t   cs;
    } hb_tf_t;

    typedef struct packed {
        hb_data_t data;
        hb_strb_t strb;
        logic     last;
    } hb_tx_t;

    typedef struct packed {
        hb_data_t data;
        logic     last;
        logic     error;
    } hb_rx_t;

endpackage

`default_nettype wire

// File: src/hyperbus_arb_pkg.sv
// HyperBus arbitration types: source index and arbiter states
`default_nettype none

`include "hyperbus_params.svh"

package hyperbus_arb_pkg;

    typedef logic [$clog2(`HB_NUM_SRC)-1:0] hb_src_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ADDR,
        ARB_DATA
    } hb_arb_state_e;

endpackage

`default_nettype wire

// File: src/hyperbus_src_port.sv
// HyperBus source port with descriptor skid register and write burst checker
`default_nettype none

module hyperbus_src_port import hyperbus_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  hb_tf_t tf_i,
    input  logic   tf_valid_i,
    output logic   tf_ready_o,
    input  hb_tx_t tx_i,
    input  logic   tx_valid_i,
    output logic   tx_ready_o,
    output hb_tf_t port_tf_o,
    output logic   port_tf_valid_o,
    input  logic   port_tf_ready_i,
    output hb_tx_t port_tx_o,
    output logic   port_tx_valid_o,
    input  logic   port_tx_ready_i,
    output logic   burst_err_o
);

    hb_tf_t  tf_q;
    logic    tf_full_q;
    logic    tf_hs_out;
    logic    tx_hs;
    hb_len_t beat_cnt_q;
    logic    burst_open_q;
    logic    burst_err_q;
    hb_len_t cnt_cur;
    logic    open_cur;

    assign tf_ready_o      = ~tf_full_q;
    assign port_tf_o       = tf_q;
    assign port_tf_valid_o = tf_full_q;
    assign tf_hs_out       = tf_full_q & port_tf_ready_i;

    // Write beats go straight through
    assign port_tx_o       = tx_i;
    assign port_tx_valid_o = tx_valid_i;
    assign tx_ready_o      = port_tx_ready_i;
    assign tx_hs           = tx_valid_i & port_tx_ready_i;

    assign burst_err_o = burst_err_q;

    always_ff @(posedge clk_i) begin
        if (tf_valid_i && !tf_full_q) begin
            tf_q <= tf_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tf_full_q <= 1'b0;
        end else if (tf_valid_i && !tf_full_q) begin
            tf_full_q <= 1'b1;
        end else if (tf_hs_out) begin
            tf_full_q <= 1'b0;
        end
    end

    // First beat may be accepted together with its descriptor
    always_comb begin
        open_cur = burst_open_q;
        cnt_cur  = beat_cnt_q;
        if (tf_hs_out) begin
            open_cur = tf_q.write;
            cnt_cur  = tf_q.len;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            burst_open_q <= 1'b0;
            beat_cnt_q   <= '0;
            burst_err_q  <= 1'b0;
        end else begin
            burst_open_q <= open_cur;
            beat_cnt_q   <= cnt_cur;
            if (tx_hs && open_cur) begin
                if (cnt_cur == '0) begin
                    burst_open_q <= 1'b0;
                    if (!tx_i.last) begin
                        burst_err_q <= 1'b1;
                    end
                end else begin
                    beat_cnt_q <= cnt_cur - 1'b1;
                    if (tx_i.last) begin
                        burst_err_q <= 1'b1;
                    end
                end
            end
        end
    end

    // Write beat held steady under back-pressure
    a_tx_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        port_tx_valid_o && !port_tx_ready_i |=> port_tx_valid_o && $stable(port_tx_o));

endmodule

`default_nettype wire

// File: src/hyperbus_arbiter.sv
// HyperBus round-robin arbiter holding the grant until the transfer completes
`default_nettype none

`include "hyperbus_params.svh"

module hyperbus_arbiter import hyperbus_pkg::*; import hyperbus_arb_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [`HB_NUM_SRC-1:0] port_valid_i,
    input  logic                   phy_tf_valid_i,
    input  logic                   phy_tf_ready_i,
    input  logic                   phy_tf_write_i,
    input  logic                   phy_rx_valid_i,
    input  logic                   phy_rx_ready_i,
    input  logic                   phy_rx_last_i,
    input  logic                   phy_b_valid_i,
    input  logic                   phy_b_ready_i,
    output hb_src_t                grant_o,
    output logic                   grant_active_o
);

    hb_arb_state_e state_q;
    hb_src_t       grant_q;
    hb_src_t       next_grant;
    logic          write_q;
    logic          done;

    // Nearest waiting source after the last one served
    always_comb begin
        int idx;
        next_grant = grant_q;
        for (int k = `HB_NUM_SRC; k >= 1; k--) begin
            idx = (int'(grant_q) + k) % `HB_NUM_SRC;
            if (port_valid_i[idx]) begin
                next_grant = hb_src_t'(idx);
            end
        end
    end

    assign done = write_q ? (phy_b_valid_i & phy_b_ready_i)
                          : (phy_rx_valid_i & phy_rx_ready_i & phy_rx_last_i);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ARB_IDLE;
            grant_q <= '0;
            write_q <= 1'b0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (|port_valid_i) begin
                        grant_q <= next_grant;
                        state_q <= ARB_ADDR;
                    end
                end
                ARB_ADDR: begin
                    if (phy_tf_valid_i && phy_tf_ready_i) begin
                        write_q <= phy_tf_write_i;
                        state_q <= ARB_DATA;
                    end
                end
                ARB_DATA: begin
                    if (done) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    assign grant_o        = grant_q;
    assign grant_active_o = (state_q != ARB_IDLE);

    // Granted port keeps its descriptor until the PHY takes it
    a_grant_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        state_q == ARB_ADDR |-> port_valid_i[grant_q]);

endmodule

`default_nettype wire

// File: src/hyperbus_phy_mux.sv
// HyperBus PHY mux: routes the granted source to the PHY channel and back
`default_nettype none

`include "hyperbus_params.svh"

module hyperbus_phy_mux import hyperbus_pkg::*; import hyperbus_arb_pkg::*; (
    input  hb_src_t                          grant_i,
    input  logic                             grant_active_i,
    input  hb_tf_t [`HB_NUM_SRC-1:0]         port_tf_i,
    input  logic [`HB_NUM_SRC-1:0]           port_tf_valid_i,
    output logic [`HB_NUM_SRC-1:0]           port_tf_ready_o,
    input  hb_tx_t [`HB_NUM_SRC-1:0]         port_tx_i,
    input  logic [`HB_NUM_SRC-1:0]           port_tx_valid_i,
    output logic [`HB_NUM_SRC-1:0]           port_tx_ready_o,
    output hb_rx_t [`HB_NUM_SRC-1:0]         src_rx_o,
    output logic [`HB_NUM_SRC-1:0]           src_rx_valid_o,
    input  logic [`HB_NUM_SRC-1:0]           src_rx_ready_i,
    output logic                             src0_b_error_o,
    output logic                             src0_b_valid_o,
    input  logic                             src0_b_ready_i,
    output hb_tf_t                           phy_tf_o,
    output logic                             phy_tf_valid_o,
    input  logic                             phy_tf_ready_i,
    output hb_tx_t                           phy_tx_o,
    output logic                             phy_tx_valid_o,
    input  logic                             phy_tx_ready_i,
    input  hb_rx_t                           phy_rx_i,
    input  logic                             phy_rx_valid_i,
    output logic                             phy_rx_ready_o,
    input  logic                             phy_b_error_i,
    input  logic                             phy_b_valid_i,
    output logic                             phy_b_ready_o
);

    logic to_src0;

    assign to_src0 = grant_active_i & (grant_i == '0);

    always_comb begin
        phy_tf_o       = port_tf_i[grant_i];
        phy_tf_valid_o = grant_active_i & port_tf_valid_i[grant_i];
        phy_tx_o       = port_tx_i[grant_i];
        phy_tx_valid_o = grant_active_i & port_tx_valid_i[grant_i];

        port_tf_ready_o          = '0;
        port_tx_ready_o          = '0;
        port_tf_ready_o[grant_i] = grant_active_i & phy_tf_ready_i;
        port_tx_ready_o[grant_i] = grant_active_i & phy_tx_ready_i;

        // Read data fans out, valid only to the owner
        for (int s = 0; s < `HB_NUM_SRC; s++) begin
            src_rx_o[s] = phy_rx_i;
        end
        src_rx_valid_o          = '0;
        src_rx_valid_o[grant_i] = grant_active_i & phy_rx_valid_i;
        phy_rx_ready_o          = grant_active_i & src_rx_ready_i[grant_i];
    end

    // Responses for other sources are acked and dropped
    assign src0_b_valid_o = to_src0 & phy_b_valid_i;
    assign src0_b_error_o = to_src0 & phy_b_error_i;
    assign phy_b_ready_o  = to_src0 ? src0_b_ready_i : 1'b1;

endmodule

`default_nettype wire

// File: src/hyperbus_front.sv
// HyperBus front end: source ports, round-robin arbiter and PHY mux
`default_nettype none

`include "hyperbus_params.svh"

module hyperbus_front import hyperbus_pkg::*; import hyperbus_arb_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  hb_tf_t [`HB_NUM_SRC-1:0] src_tf_i,
    input  logic [`HB_NUM_SRC-1:0]   src_tf_valid_i,
    output logic [`HB_NUM_SRC-1:0]   src_tf_ready_o,
    input  hb_tx_t [`HB_NUM_SRC-1:0] src_tx_i,
    input  logic [`HB_NUM_SRC-1:0]   src_tx_valid_i,
    output logic [`HB_NUM_SRC-1:0]   src_tx_ready_o,
    output hb_rx_t [`HB_NUM_SRC-1:0] src_rx_o,
    output logic [`HB_NUM_SRC-1:0]   src_rx_valid_o,
    input  logic [`HB_NUM_SRC-1:0]   src_rx_ready_i,
    output logic [`HB_NUM_SRC-1:0]   src_burst_err_o,
    output logic                     src0_b_error_o,
    output logic                     src0_b_valid_o,
    input  logic                     src0_b_ready_i,
    output hb_tf_t                   phy_tf_o,
    output logic                     phy_tf_valid_o,
    input  logic                     phy_tf_ready_i,
    output hb_tx_t                   phy_tx_o,
    output logic                     phy_tx_valid_o,
    input  logic                     phy_tx_ready_i,
    input  hb_rx_t                   phy_rx_i,
    input  logic                     phy_rx_valid_i,
    output logic                     phy_rx_ready_o,
    input  logic                     phy_b_error_i,
    input  logic                     phy_b_valid_i,
    output logic                     phy_b_ready_o
);

    hb_tf_t [`HB_NUM_SRC-1:0] port_tf;
    logic [`HB_NUM_SRC-1:0]   port_tf_valid;
    logic [`HB_NUM_SRC-1:0]   port_tf_ready;
    hb_tx_t [`HB_NUM_SRC-1:0] port_tx;
    logic [`HB_NUM_SRC-1:0]   port_tx_valid;
    logic [`HB_NUM_SRC-1:0]   port_tx_ready;
    hb_src_t                  grant;
    logic                     grant_active;

    for (genvar i = 0; i < `HB_NUM_SRC; i++) begin : g_src
        hyperbus_src_port i_src_port (
            .clk_i           ( clk_i             ),
            .rst_n_i         ( rst_n_i           ),
            .tf_i            ( src_tf_i[i]       ),
            .tf_valid_i      ( src_tf_valid_i[i] ),
            .tf_ready_o      ( src_tf_ready_o[i] ),
            .tx_i            ( src_tx_i[i]       ),
            .tx_valid_i      ( src_tx_valid_i[i] ),
            .tx_ready_o      ( src_tx_ready_o[i] ),
            .port_tf_o       ( port_tf[i]        ),
            .port_tf_valid_o ( port_tf_valid[i]  ),
            .port_tf_ready_i ( port_tf_ready[i]  ),
            .port_tx_o       ( port_tx[i]        ),
            .port_tx_valid_o ( port_tx_valid[i]  ),
            .port_tx_ready_i ( port_tx_ready[i]  ),
            .burst_err_o     ( src_burst_err_o[i] )
        );
    end

    hyperbus_arbiter i_arbiter (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .port_valid_i   ( port_tf_valid  ),
        .phy_tf_valid_i ( phy_tf_valid_o ),
        .phy_tf_ready_i ( phy_tf_ready_i ),
        .phy_tf_write_i ( phy_tf_o.write ),
        .phy_rx_valid_i ( phy_rx_valid_i ),
        .phy_rx_ready_i ( phy_rx_ready_o ),
        .phy_rx_last_i  ( phy_rx_i.last  ),
        .phy_b_valid_i  ( phy_b_valid_i  ),
        .phy_b_ready_i  ( phy_b_ready_o  ),
        .grant_o        ( grant          ),
        .grant_active_o ( grant_active   )
    );

    hyperbus_phy_mux i_phy_mux (
        .grant_i         ( grant          ),
        .grant_active_i  ( grant_active   ),
        .port_tf_i       ( port_tf        ),
        .port_tf_valid_i ( port_tf_valid  ),
        .port_tf_ready_o ( port_tf_ready  ),
        .port_tx_i       ( port_tx        ),
        .port_tx_valid_i ( port_tx_valid  ),
        .port_tx_ready_o ( port_tx_ready  ),
        .src_rx_o        ( src_rx_o       ),
        .src_rx_valid_o  ( src_rx_valid_o ),
        .src_rx_ready_i  ( src_rx_ready_i ),
        .src0_b_error_o  ( src0_b_error_o ),
        .src0_b_valid_o  ( src0_b_valid_o ),
        .src0_b_ready_i  ( src0_b_ready_i ),
        .phy_tf_o        ( phy_tf_o       ),
        .phy_tf_valid_o  ( phy_tf_valid_o ),
        .phy_tf_ready_i  ( phy_tf_ready_i ),
        .phy_tx_o        ( phy_tx_o       ),
        .phy_tx_valid_o  ( phy_tx_valid_o ),
        .phy_tx_ready_i  ( phy_tx_ready_i ),
        .phy_rx_i        ( phy_rx_i       ),
        .phy_rx_valid_i  ( phy_rx_valid_i ),
        .phy_rx_ready_o  ( phy_rx_ready_o ),
        .phy_b_error_i   ( phy_b_error_i  ),
        .phy_b_valid_i   ( phy_b_valid_i  ),
        .phy_b_ready_o   ( phy_b_ready_o  )
    );

endmodule

`default_nettype wire

// File: tb/tb_hyperbus_front.sv
// Random-stimulus testbench for the HyperBus front end with PHY responder and model
`default_nettype none

`include "hyperbus_params.svh"

module tb_hyperbus_front import hyperbus_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NS = `HB_NUM_SRC;
    localparam int XFERS_PER_SRC = 100;
    localparam int CYCLES_PER_XFER = 40;
    localparam int CLK_NS = 8;
    localparam int WATCHDOG_NS = 400 * CYCLES_PER_XFER * CLK_NS;

    logic            clk;
    logic            rst_n;
    hb_tf_t [NS-1:0] src_tf;
    logic [NS-1:0]   src_tf_valid;
    logic [NS-1:0]   src_tf_ready;
    hb_tx_t [NS-1:0] src_tx;
    logic [NS-1:0]   src_tx_valid;
    logic [NS-1:0]   src_tx_ready;
    hb_rx_t [NS-1:0] src_rx;
    logic [NS-1:0]   src_rx_valid;
    logic [NS-1:0]   src_rx_ready;
    logic [NS-1:0]   burst_err;
    logic            b_error;
    logic            b_valid;
    logic            b_ready;
    hb_tf_t          phy_tf;
    logic            phy_tf_valid;
    logic            phy_tf_ready;
    hb_tx_t          phy_tx;
    logic            phy_tx_valid;
    logic            phy_tx_ready;
    hb_rx_t          phy_rx;
    logic            phy_rx_valid;
    logic            phy_rx_ready;
    logic            phy_b_error;
    logic            phy_b_valid;
    logic            phy_b_ready;

    logic [31:0] seed;
    int          err_value;
    int          err_other;
    // Per source accepted descriptors, beats to drive and beats in flight
    hb_tf_t      exp_tf[NS][$];
    hb_tx_t      send_tx[NS][$];
    logic        send_bad[NS][$];
    hb_tx_t      exp_tx[NS][$];
    int          issued[NS];
    logic        port_full[NS];
    logic        err_model[NS];
    logic        arb_idle;
    int          last_served;
    int          win;
    logic        xfer_open;
    int          cur_src;
    hb_tf_t      cur_tf;
    int          rx_seen;
    int          tx_seen;
    int          n_tf;
    int          n_tx;
    int          n_rx;
    int          n_b0;
    int          exp_b0;
    int          gen_beats;
    int          gen_reads;
    // PHY responder state
    logic        r_busy;
    hb_tf_t      r_tf;
    int          r_tx_left;
    int          r_rx_idx;

    hyperbus_front UUT (
        .clk_i          ( clk          ),
        .rst_n_i        ( rst_n        ),
        .src_tf_i       ( src_tf       ),
        .src_tf_valid_i ( src_tf_valid ),
        .src_tf_ready_o ( src_tf_ready ),
        .src_tx_i       ( src_tx       ),
        .src_tx_valid_i ( src_tx_valid ),
        .src_tx_ready_o ( src_tx_ready ),
        .src_rx_o       ( src_rx       ),
        .src_rx_valid_o ( src_rx_valid ),
        .src_rx_ready_i ( src_rx_ready ),
        .src_burst_err_o( burst_err    ),
        .src0_b_error_o ( b_error      ),
        .src0_b_valid_o ( b_valid      ),
        .src0_b_ready_i ( b_ready      ),
        .phy_tf_o       ( phy_tf       ),
        .phy_tf_valid_o ( phy_tf_valid ),
        .phy_tf_ready_i ( phy_tf_ready ),
        .phy_tx_o       ( phy_tx       ),
        .phy_tx_valid_o ( phy_tx_valid ),
        .phy_tx_ready_i ( phy_tx_ready ),
        .phy_rx_i       ( phy_rx       ),
        .phy_rx_valid_i ( phy_rx_valid ),
        .phy_rx_ready_o ( phy_rx_ready ),
        .phy_b_error_i  ( phy_b_error  ),
        .phy_b_valid_i  ( phy_b_valid  ),
        .phy_b_ready_o  ( phy_b_ready  )
    );

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic chance(int pct);
        return ((next_random() >> 8) % 32'd100) < 32'(pct);
    endfunction

    // Read data is a function of address and beat index
    function automatic hb_rx_t read_beat(hb_tf_t tf, int idx);
        hb_rx_t beat;
        beat.data  = tf.addr[15:0] ^ tf.addr[31:16] ^ hb_data_t'(idx * 40503);
        beat.last  = (idx == int'(tf.len));
        beat.error = ^beat.data[3:0];
        return beat;
    endfunction

    task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
        $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        err_value++;
    endtask

    task automatic report_fault(string what);
        $display("ERROR at %0t: %s", $time, what);
        err_other++;
    endtask

    task automatic issue_descriptor(int s);
        hb_tf_t tf;
        hb_tx_t beat;
        int     bad_idx;
        tf.write = chance(50);
        tf.len   = hb_len_t'((next_random() >> 8) % 32'd8);
        tf.cs    = chance(50) ? hb_cs_t'(2'b01) : hb_cs_t'(2'b10);
        // Top bit names the source, then a sequence number
        tf.addr  = {1'(s), 15'(issued[s]), 16'(next_random() >> 12)};
        bad_idx  = -1;
        if (tf.write && chance(6)) begin
            bad_idx = int'((next_random() >> 8) % (32'(tf.len) + 32'd1));
        end
        for (int k = 0; k <= int'(tf.len); k++) begin
            if (tf.write) begin
                beat.data = hb_data_t'(next_random() >> 8);
                beat.strb = hb_strb_t'(next_random() >> 24);
                beat.last = (k == int'(tf.len)) ^ (k == bad_idx);
                send_tx[s].push_back(beat);
                send_bad[s].push_back(k == bad_idx);
            end
        end
        if (tf.write) begin
            gen_beats += int'(tf.len) + 1;
        end else begin
            gen_reads += int'(tf.len) + 1;
        end
        src_tf[s]       <= tf;
        src_tf_valid[s] <= 1'b1;
        issued[s]++;
    endtask

    task automatic drive_sources();
        for (int s = 0; s < NS; s++) begin
            if (!src_tf_valid[s] || src_tf_ready[s]) begin
                if (issued[s] < XFERS_PER_SRC && chance(40)) begin
                    issue_descriptor(s);
                end else begin
                    src_tf_valid[s] <= 1'b0;
                end
            end
            if (!src_tx_valid[s] || src_tx_ready[s]) begin
                if (send_tx[s].size() > 0 && chance(70)) begin
                    src_tx[s]       <= send_tx[s][0];
                    src_tx_valid[s] <= 1'b1;
                end else begin
                    src_tx_valid[s] <= 1'b0;
                end
            end
            src_rx_ready[s] <= chance(70);
        end
        b_ready <= chance(60);
    endtask

    task automatic run_responder();
        if (phy_tf_valid && phy_tf_ready) begin
            r_busy    = 1'b1;
            r_tf      = phy_tf;
            r_tx_left = r_tf.write ? int'(r_tf.len) + 1 : 0;
            r_rx_idx  = 0;
        end
        if (phy_tx_valid && phy_tx_ready) begin
            r_tx_left--;
            if (r_tx_left == 0) begin
                phy_b_valid <= 1'b1;
                phy_b_error <= ^r_tf.addr;
            end
        end
        if (phy_b_valid && phy_b_ready) begin
            phy_b_valid <= 1'b0;
            r_busy = 1'b0;
        end
        if (phy_rx_valid && phy_rx_ready) begin
            r_rx_idx++;
            if (r_rx_idx > int'(r_tf.len)) begin
                r_busy = 1'b0;
            end
        end
        if (!phy_rx_valid || phy_rx_ready) begin
            if (r_busy && !r_tf.write && chance(75)) begin
                phy_rx       <= read_beat(r_tf, r_rx_idx);
                phy_rx_valid <= 1'b1;
            end else begin
                phy_rx_valid <= 1'b0;
            end
        end
        phy_tf_ready <= !r_busy && chance(60);
        phy_tx_ready <= r_busy && r_tf.write && r_tx_left > 0 && chance(60);
    endtask

    task automatic track_and_check();
        logic   was_idle;
        logic   b0_exp;
        int     ps;
        hb_tf_t exp_d;
        hb_tx_t exp_b;
        hb_rx_t exp_r;
        for (int i = 0; i < NS; i++) begin
            if (burst_err[i] !== err_model[i]) begin
                report_mismatch($sformatf("burst_err[%0d]", i), 64'(err_model[i]),
                                64'(burst_err[i]));
            end
            if (src_tf_ready[i] !== !port_full[i]) begin
                report_mismatch($sformatf("tf_ready[%0d]", i), 64'(!port_full[i]),
                                64'(src_tf_ready[i]));
            end
            if (src_rx_valid[i] && !(xfer_open && !cur_tf.write && cur_src == i)) begin
                report_fault($sformatf("read beat offered to source %0d outside its read", i));
            end
            if (src_tx_ready[i] && !(xfer_open && cur_tf.write && cur_src == i)) begin
                report_fault($sformatf("write ready given to source %0d outside its write", i));
            end
        end
        b0_exp = xfer_open && cur_src == 0 && cur_tf.write && phy_b_valid;
        if (b_valid !== b0_exp) begin
            report_mismatch("src0_b_valid", 64'(b0_exp), 64'(b_valid));
        end
        if (phy_b_valid && xfer_open && cur_src != 0 && !phy_b_ready) begin
            report_fault("write response of source 1 was not acknowledged");
        end

        // Round-robin choice at an idle point
        was_idle = arb_idle;
        if (arb_idle && (port_full[0] || port_full[1])) begin
            if (port_full[0] && port_full[1]) begin
                win = 1 - last_served;
            end else begin
                win = port_full[1] ? 1 : 0;
            end
            last_served = win;
            arb_idle    = 1'b0;
        end

        for (int i = 0; i < NS; i++) begin
            if (src_tf_valid[i] && src_tf_ready[i]) begin
                exp_tf[i].push_back(src_tf[i]);
                port_full[i] = 1'b1;
                if (i == 0 && src_tf[i].write) begin
                    exp_b0++;
                end
            end
            if (src_tx_valid[i] && src_tx_ready[i]) begin
                exp_tx[i].push_back(src_tx[i]);
                void'(send_tx[i].pop_front());
                if (send_bad[i].pop_front()) begin
                    err_model[i] = 1'b1;
                end
                if (xfer_open && cur_src == i) begin
                    tx_seen++;
                end
            end
            if (src_rx_valid[i] && src_rx_ready[i] && xfer_open && cur_src == i) begin
                exp_r = read_beat(cur_tf, rx_seen);
                if (src_rx[i] !== exp_r) begin
                    report_mismatch("read beat", 64'(exp_r), 64'(src_rx[i]));
                end
                rx_seen++;
                n_rx++;
            end
        end
        if (b_valid && b_ready) begin
            if (b_error !== ^cur_tf.addr) begin
                report_mismatch("src0_b_error", 64'(^cur_tf.addr), 64'(b_error));
            end
            n_b0++;
        end

        if (phy_tf_valid && phy_tf_ready) begin
            ps = int'(phy_tf.addr[31]);
            if (xfer_open || was_idle) begin
                report_fault("descriptor reached the PHY before a grant was due");
            end
            if (ps != win) begin
                report_mismatch("grant order", 64'(win), 64'(ps));
            end
            if (exp_tf[ps].size() == 0) begin
                report_fault($sformatf("descriptor at the PHY never sent by source %0d", ps));
                cur_tf = phy_tf;
            end else begin
                exp_d = exp_tf[ps].pop_front();
                if (phy_tf !== exp_d) begin
                    report_mismatch("descriptor", 64'(exp_d), 64'(phy_tf));
                end
                cur_tf = exp_d;
            end
            port_full[ps] = 1'b0;
            xfer_open     = 1'b1;
            cur_src       = ps;
            rx_seen       = 0;
            tx_seen       = 0;
            n_tf++;
        end
        if (phy_tx_valid && phy_tx_ready) begin
            if (!xfer_open || !cur_tf.write || exp_tx[cur_src].size() == 0) begin
                report_fault("write beat reached the PHY outside a write burst");
            end else begin
                exp_b = exp_tx[cur_src].pop_front();
                if (phy_tx !== exp_b) begin
                    report_mismatch("write beat", 64'(exp_b), 64'(phy_tx));
                end
            end
            n_tx++;
        end

        // Completion handshakes close the transfer
        if (xfer_open && cur_tf.write && phy_b_valid && phy_b_ready) begin
            if (tx_seen != int'(cur_tf.len) + 1) begin
                report_mismatch("beats per write", 64'(cur_tf.len) + 1, 64'(tx_seen));
            end
            xfer_open = 1'b0;
            arb_idle  = 1'b1;
        end
        if (xfer_open && !cur_tf.write && phy_rx_valid && phy_rx_ready && phy_rx.last) begin
            if (rx_seen != int'(cur_tf.len) + 1) begin
                report_mismatch("beats per read", 64'(cur_tf.len) + 1, 64'(rx_seen));
            end
            xfer_open = 1'b0;
            arb_idle  = 1'b1;
        end
    endtask

    function automatic logic all_done();
        logic busy;
        busy = xfer_open || r_busy;
        for (int s = 0; s < NS; s++) begin
            busy = busy || issued[s] < XFERS_PER_SRC || send_tx[s].size() > 0;
            busy = busy || port_full[s] || src_tf_valid[s];
        end
        return !busy;
    endfunction

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns with %0d of %0d descriptors at the PHY",
                 WATCHDOG_NS, n_tf, NS * XFERS_PER_SRC);
        $display("tests failed");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        src_tf       = '0;
        src_tf_valid = '0;
        src_tx       = '0;
        src_tx_valid = '0;
        src_rx_ready = '0;
        b_ready      = 1'b0;
        phy_tf_ready = 1'b0;
        phy_tx_ready = 1'b0;
        phy_rx       = '0;
        phy_rx_valid = 1'b0;
        phy_b_error  = 1'b0;
        phy_b_valid  = 1'b0;
        seed         = 32'ha70f9040;
        err_value    = 0;
        err_other    = 0;
        for (int s = 0; s < NS; s++) begin
            issued[s]    = 0;
            port_full[s] = 1'b0;
            err_model[s] = 1'b0;
        end
        arb_idle    = 1'b1;
        last_served = 0;
        win         = 0;
        xfer_open   = 1'b0;
        cur_src     = 0;
        cur_tf      = '0;
        rx_seen     = 0;
        tx_seen     = 0;
        n_tf        = 0;
        n_tx        = 0;
        n_rx        = 0;
        n_b0        = 0;
        exp_b0      = 0;
        gen_beats   = 0;
        gen_reads   = 0;
        r_busy      = 1'b0;
        r_tf        = '0;
        r_tx_left   = 0;
        r_rx_idx    = 0;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        while (!all_done()) begin
            @(posedge clk);
            track_and_check();
            run_responder();
            drive_sources();
        end

        for (int s = 0; s < NS; s++) begin
            if (exp_tf[s].size() != 0 || exp_tx[s].size() != 0) begin
                report_fault($sformatf("source %0d traffic never reached the PHY", s));
            end
        end
        if (n_tf != NS * XFERS_PER_SRC) begin
            report_mismatch("descriptor total", 64'(NS * XFERS_PER_SRC), 64'(n_tf));
        end
        if (n_tx != gen_beats) begin
            report_mismatch("write beat total", 64'(gen_beats), 64'(n_tx));
        end
        if (n_rx != gen_reads) begin
            report_mismatch("read beat total", 64'(gen_reads), 64'(n_rx));
        end
        if (n_b0 != exp_b0) begin
            report_mismatch("source 0 write responses", 64'(exp_b0), 64'(n_b0));
        end
        $display("summary: %0d value errors, %0d other errors, %0d tf, %0d tx, %0d rx",
                 err_value, err_other, n_tf, n_tx, n_rx);
        if (err_value == 0 && err_other == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+src
src/hyperbus_pkg.sv
src/hyperbus_arb_pkg.sv
src/hyperbus_src_port.sv
src/hyperbus_arbiter.sv
src/hyperbus_phy_mux.sv
src/hyperbus_front.sv
tb/tb_hyperbus_front.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_hyperbus_front \
    -f all.f -o tb_hyperbus_front > build.log 2>&1 \
    && ./obj_dir/tb_hyperbus_front > sim.log 2>&1 \
    || echo "build or simulation did not complete, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
